/* Bender.yml */
package:
  name: conv_engine

sources:
  - include_dirs:
      - source
    files:
      - source/conv_pkg.sv
      - source/conv_if.sv
      - source/conv_sequencer.sv
      - source/window_counter.sv
      - source/pixel_buffer.sv
      - source/kernel_mac.sv
      - source/requant_unit.sv
      - source/conv_engine.sv
  - target: test
    include_dirs:
      - source
      - verification
    files:
      - verification/conv_engine_assertions.sv
      - verification/conv_engine_tb.sv

/* flist.f */
+incdir+source
+incdir+verification
source/conv_pkg.sv
source/conv_if.sv
source/conv_sequencer.sv
source/window_counter.sv
source/pixel_buffer.sv
source/kernel_mac.sv
source/requant_unit.sv
source/conv_engine.sv
verification/conv_engine_assertions.sv
verification/conv_engine_tb.sv

/* source/conv_engine.sv */
`include "conv_settings.svh"

module conv_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic                    pix_wr_en,
    input  logic [`CONV_ADDR_W-1:0] pix_wr_addr,
    input  conv_pkg::pixel_t        pix_wr_data,
    input  logic                    w_wr_en,
    input  logic [`CONV_TAP_W-1:0]  w_wr_idx,
    input  conv_pkg::weight_t       w_wr_data,
    input  conv_pkg::bias_t         bias,
    input  conv_pkg::scale_t        scale,
    input  conv_pkg::rank_t         rank,
    output logic                    busy,
    output logic                    out_valid,
    output conv_pkg::coord_t        out_x,
    output conv_pkg::coord_t        out_y,
    output conv_pkg::qout_t         out_data,
    output logic                    done
);
    import conv_pkg::*;

    logic   sweep_en;
    logic   sweep_end;
    pixel_t pixel;

    tap_if taps_rd ();   // from the counter
    tap_if taps_px ();   // aligned with the read pixel
    acc_if accs ();

    conv_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .sweep_end (sweep_end),
        .sweep_en  (sweep_en),
        .busy      (busy),
        .done      (done)
    );

    window_counter u_window_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .sweep_en  (sweep_en),
        .sweep_end (sweep_end),
        .taps      (taps_rd.source)
    );

    pixel_buffer u_pixel_buffer (
        .clk         (clk),
        .pix_wr_en   (pix_wr_en),
        .pix_wr_addr (pix_wr_addr),
        .pix_wr_data (pix_wr_data),
        .taps_in     (taps_rd.sink),
        .taps_out    (taps_px.source),
        .pixel       (pixel)
    );

    kernel_mac u_kernel_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_wr_en   (w_wr_en),
        .w_wr_idx  (w_wr_idx),
        .w_wr_data (w_wr_data),
        .taps      (taps_px.sink),
        .pixel     (pixel),
        .accs      (accs.source)
    );

    requant_unit u_requant (
        .clk       (clk),
        .rst_n     (rst_n),
        .bias      (bias),
        .scale     (scale),
        .rank      (rank),
        .accs      (accs.sink),
        .out_valid (out_valid),
        .out_x     (out_x),
        .out_y     (out_y),
        .out_data  (out_data)
    );

endmodule

/* source/conv_if.sv */
`include "conv_settings.svh"

//////////////////////////////////////////////////
// one kernel tap plus its tags
//////////////////////////////////////////////////

interface tap_if;
    logic                      tap_valid;
    logic [`CONV_ADDR_W-1:0]   rd_addr;     // pixel buffer address
    logic [`CONV_TAP_W-1:0]    tap_idx;     // 0..8, raster order in kernel
    logic                      first_tap;
    logic                      last_tap;
    conv_pkg::coord_t          tap_x;       // output position of this tap
    conv_pkg::coord_t          tap_y;

    modport source (
        output tap_valid, rd_addr, tap_idx, first_tap, last_tap, tap_x, tap_y
    );

    modport sink (
        input  tap_valid, rd_addr, tap_idx, first_tap, last_tap, tap_x, tap_y
    );
endinterface

//////////////////////////////////////////////////
// finished sum for one output position
//////////////////////////////////////////////////

interface acc_if;
    logic                acc_valid;
    conv_pkg::acc_t      acc;
    conv_pkg::coord_t    acc_x;
    conv_pkg::coord_t    acc_y;

    modport source (
        output acc_valid, acc, acc_x, acc_y
    );

    modport sink (
        input  acc_valid, acc, acc_x, acc_y
    );
endinterface

/* source/conv_pkg.sv */
`include "conv_settings.svh"

package conv_pkg;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,
        RUN,     // taps being issued
        DRAIN,   // pipeline emptying
        FINISH   // done pulse
    } conv_state_e;

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////

    typedef logic        [7:0]                 pixel_t;   // unsigned feature map pixel
    typedef logic signed [7:0]                 weight_t;
    typedef logic signed [15:0]                bias_t;
    typedef logic signed [`CONV_ACC_W-1:0]     acc_t;
    typedef logic        [`CONV_SCALE_W-1:0]   scale_t;   // scale tail
    typedef logic        [`CONV_RANK_W-1:0]    rank_t;    // right shift amount

    // output x / y index
    typedef logic        [3:0]                 coord_t;

    // requantized result
    typedef logic signed [7:0]                 qout_t;

endpackage

/* source/conv_sequencer.sv */
`include "conv_settings.svh"

module conv_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic sweep_end,
    output logic sweep_en,
    output logic busy,
    output logic done
);
    import conv_pkg::*;

    localparam int DRAIN_W = $clog2(`CONV_DRAIN + 1);
    localparam logic [DRAIN_W-1:0] DRAIN_LAST = DRAIN_W'(`CONV_DRAIN - 1);

    conv_state_e state;
    conv_state_e state_nxt;
    logic [DRAIN_W-1:0] drain_cnt;   // cycles spent in DRAIN

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            drain_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == DRAIN) begin
                drain_cnt <= drain_cnt + 1'b1;
            end else begin
                drain_cnt <= '0;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = RUN;   // start ignored elsewhere
                end
            end
            RUN: begin
                if (sweep_end) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                // last output leaves requant in the final drain cycle
                if (drain_cnt == DRAIN_LAST) begin
                    state_nxt = FINISH;
                end
            end
            FINISH: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign sweep_en = (state == RUN);
    assign busy     = (state != IDLE);
    assign done     = (state == FINISH);   // one cycle only

endmodule

/* source/conv_settings.svh */
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

//////////////////////////////////////////////////
// image and kernel geometry
//////////////////////////////////////////////////

`define CONV_IMG_W    8                     // input pixels per row
`define CONV_IMG_H    6                     // input rows
`define CONV_K        3                     // kernel is K x K
`define CONV_TAPS     9                     // K * K taps per output
`define CONV_OUT_W    (`CONV_IMG_W - 2)     // no padding, stride 1
`define CONV_OUT_H    (`CONV_IMG_H - 2)

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

`define CONV_ADDR_W   6                     // covers IMG_W * IMG_H
`define CONV_TAP_W    4
`define CONV_ACC_W    24                    // nine 8x9 bit products plus bias
`define CONV_SCALE_W  16
`define CONV_RANK_W   5

// last issued tap to last out_valid:
// buffer read, mac, requant register
`define CONV_DRAIN    3

`endif

/* source/kernel_mac.sv */
`include "conv_settings.svh"

module kernel_mac (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   w_wr_en,
    input  logic [`CONV_TAP_W-1:0] w_wr_idx,
    input  conv_pkg::weight_t      w_wr_data,
    tap_if.sink                    taps,
    input  conv_pkg::pixel_t       pixel,
    acc_if.source                  accs
);
    import conv_pkg::*;

    weight_t weights [`CONV_TAPS];   // raster order, same as tap_idx
    acc_t    product;
    acc_t    sum;
    acc_t    sum_nxt;

    always_ff @(posedge clk) begin
        if (w_wr_en) begin
            weights[w_wr_idx] <= w_wr_data;
        end
    end

    // pixel is unsigned, widen with a zero before the signed multiply
    assign product = $signed({1'b0, pixel}) * weights[taps.tap_idx];
    assign sum_nxt = taps.first_tap ? product : sum + product;

    always_ff @(posedge clk) begin
        if (taps.tap_valid) begin
            sum <= sum_nxt;
        end
    end

    //////////////////////////////////////////////////
    // result register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accs.acc_valid <= 1'b0;
        end else begin
            accs.acc_valid <= taps.tap_valid && taps.last_tap;
        end
    end

    always_ff @(posedge clk) begin
        if (taps.tap_valid && taps.last_tap) begin
            accs.acc   <= sum_nxt;       // includes the ninth product
            accs.acc_x <= taps.tap_x;
            accs.acc_y <= taps.tap_y;
        end
    end

endmodule

/* source/pixel_buffer.sv */
`include "conv_settings.svh"

module pixel_buffer (
    input  logic                    clk,
    input  logic                    pix_wr_en,
    input  logic [`CONV_ADDR_W-1:0] pix_wr_addr,
    input  conv_pkg::pixel_t        pix_wr_data,
    tap_if.sink                     taps_in,
    tap_if.source                   taps_out,
    output conv_pkg::pixel_t        pixel
);
    import conv_pkg::*;

    localparam int DEPTH = `CONV_IMG_W * `CONV_IMG_H;

    pixel_t mem [DEPTH];   // one feature map, row major

    always_ff @(posedge clk) begin
        if (pix_wr_en) begin
            mem[pix_wr_addr] <= pix_wr_data;
        end
    end

    // synchronous read
    always_ff @(posedge clk) begin
        pixel <= mem[taps_in.rd_addr];
    end

    //////////////////////////////////////////////////
    // tags follow the read by one cycle
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        taps_out.tap_valid <= taps_in.tap_valid;
        taps_out.rd_addr   <= taps_in.rd_addr;     // address the pixel came from
        taps_out.tap_idx   <= taps_in.tap_idx;
        taps_out.first_tap <= taps_in.first_tap;
        taps_out.last_tap  <= taps_in.last_tap;
        taps_out.tap_x     <= taps_in.tap_x;
        taps_out.tap_y     <= taps_in.tap_y;
    end

endmodule

/* source/requant_unit.sv */
`include "conv_settings.svh"

module requant_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  conv_pkg::bias_t  bias,
    input  conv_pkg::scale_t scale,
    input  conv_pkg::rank_t  rank,
    acc_if.sink              accs,
    output logic             out_valid,
    output conv_pkg::coord_t out_x,
    output conv_pkg::coord_t out_y,
    output conv_pkg::qout_t  out_data
);
    import conv_pkg::*;

    // signed acc times unsigned scale, one extra bit for the sign
    localparam int PROD_W = `CONV_ACC_W + `CONV_SCALE_W + 1;

    acc_t                     biased;
    logic signed [PROD_W-1:0] scaled;
    logic signed [PROD_W-1:0] shifted;
    qout_t                    clamped;

    assign biased  = accs.acc + bias;
    assign scaled  = biased * $signed({1'b0, scale});
    assign shifted = scaled >>> rank;   // floor, no rounding

    always_comb begin
        if (shifted > 127) begin
            clamped = 8'sd127;
        end else if (shifted < -128) begin
            clamped = -8'sd128;
        end else begin
            clamped = qout_t'(shifted);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accs.acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accs.acc_valid) begin
            out_data <= clamped;
            out_x    <= accs.acc_x;
            out_y    <= accs.acc_y;
        end
    end

endmodule

/* source/window_counter.sv */
`include "conv_settings.svh"

module window_counter (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sweep_en,
    output logic  sweep_end,
    tap_if.source taps
);
    import conv_pkg::*;

    localparam int KW = $clog2(`CONV_K);
    localparam int TW = `CONV_TAP_W;
    localparam int AW = `CONV_ADDR_W;

    localparam logic [TW-1:0] TAP_LAST = TW'(`CONV_TAPS - 1);
    localparam logic [KW-1:0] K_LAST   = KW'(`CONV_K - 1);
    localparam coord_t        X_LAST   = coord_t'(`CONV_OUT_W - 1);
    localparam coord_t        Y_LAST   = coord_t'(`CONV_OUT_H - 1);

    logic [TW-1:0] tap;
    logic [KW-1:0] kx;         // kernel column
    logic [KW-1:0] ky;         // kernel row
    coord_t        x;
    coord_t        y;
    logic [AW-1:0] row;
    logic [AW-1:0] col;
    logic          tap_end;
    logic          x_end;
    logic          y_end;

    assign tap_end = (tap == TAP_LAST);
    assign x_end   = (x == X_LAST);
    assign y_end   = (y == Y_LAST);

    // taps inside outputs, outputs in raster order
    always_ff @(posedge clk) begin
        if (!rst_n || !sweep_en) begin
            tap <= '0;
            kx  <= '0;
            ky  <= '0;
            x   <= '0;
            y   <= '0;
        end else if (tap_end) begin
            tap <= '0;
            kx  <= '0;
            ky  <= '0;
            if (x_end) begin
                x <= '0;
                y <= y_end ? coord_t'(0) : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end else begin
            tap <= tap + 1'b1;
            if (kx == K_LAST) begin
                kx <= '0;
                ky <= ky + 1'b1;
            end else begin
                kx <= kx + 1'b1;
            end
        end
    end

    // input pixel under this tap
    assign row = AW'(y) + AW'(ky);
    assign col = AW'(x) + AW'(kx);

    assign taps.tap_valid = sweep_en;
    assign taps.rd_addr   = row * AW'(`CONV_IMG_W) + col;
    assign taps.tap_idx   = tap;
    assign taps.first_tap = sweep_en && (tap == '0);
    assign taps.last_tap  = sweep_en && tap_end;
    assign taps.tap_x     = x;
    assign taps.tap_y     = y;

    assign sweep_end = sweep_en && tap_end && x_end && y_end;   // with the final tap

endmodule

/* verification/conv_engine_assertions.sv */
module conv_engine_assertions (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic out_valid,
    input logic done
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count;   // failed assertions so far

    initial fail_count = 0;

    // last output leaves in the final drain cycle, done follows
    done_apart_from_output: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && out_valid))
        else begin
            $error("done and out_valid high together");
            fail_count++;
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            $error("done held for more than one cycle");
            fail_count++;
        end

    output_only_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> busy)
        else begin
            $error("out_valid while busy is low");
            fail_count++;
        end

endmodule

bind conv_engine conv_engine_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .out_valid (out_valid),
    .done      (done)
);

/* verification/conv_engine_tests.svh */
`ifndef CONV_ENGINE_TESTS_SVH
`define CONV_ENGINE_TESTS_SVH

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////

task automatic check_qout(input string name, input qout_t exp, input qout_t act);
    if (act !== exp) begin
        $display("[ERROR] %s: out_data expected %0d, got %0d", name, exp, act);
        error_count++;
    end
endtask

task automatic check_coord(input string name, input string field,
                           input coord_t exp, input coord_t act);
    if (act !== exp) begin
        $display("[ERROR] %s: %s expected %0d, got %0d", name, field, exp, act);
        error_count++;
    end
endtask

task automatic check_count(input string name, input string field, input int exp, input int act);
    if (act != exp) begin
        $display("[ERROR] %s: %s expected %0d, got %0d", name, field, exp, act);
        error_count++;
    end
endtask

task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
        tests_failed++;
        $display("%s: failed with %0d errors", name, error_count - errs_before);
    end else begin
        $display("%s: ok", name);
    end
endtask

//////////////////////////////////////////////////
// stimulus helpers
//////////////////////////////////////////////////

task automatic load_image();
    int a;
    for (a = 0; a < IMG_PIX; a++) begin
        @(posedge clk);
        pix_wr_en   <= 1'b1;
        pix_wr_addr <= `CONV_ADDR_W'(a);
        pix_wr_data <= img[a];
    end
    @(posedge clk);
    pix_wr_en <= 1'b0;
endtask

task automatic load_kernel();
    int i;
    for (i = 0; i < `CONV_TAPS; i++) begin
        @(posedge clk);
        w_wr_en   <= 1'b1;
        w_wr_idx  <= `CONV_TAP_W'(i);
        w_wr_data <= kern[i];
    end
    @(posedge clk);
    w_wr_en <= 1'b0;
endtask

task automatic set_requant(input bias_t b, input scale_t s, input rank_t r);
    @(posedge clk);
    bias  <= b;
    scale <= s;
    rank  <= r;
endtask

// start pulse, then collect outputs in raster order until done
task automatic run_and_check(input string name);
    int n_out;
    int ox;
    int oy;
    bit finished;
    n_out    = 0;
    finished = 1'b0;
    @(negedge clk);
    if (busy) begin
        $display("%s: busy already high before start", name);
        error_count++;
    end
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!finished) begin
        @(negedge clk);
        if (!busy) begin
            $display("%s: busy dropped before done", name);
            error_count++;
        end
        if (done && out_valid) begin
            $display("%s: done and out_valid high in the same cycle", name);
            error_count++;
        end
        if (out_valid) begin
            ox = n_out % `CONV_OUT_W;
            oy = n_out / `CONV_OUT_W;
            check_coord(name, "out_x", coord_t'(ox), out_x);
            check_coord(name, "out_y", coord_t'(oy), out_y);
            check_qout(name, model_out(ox, oy), out_data);
            n_out++;
        end
        finished = done || !busy;
    end
    check_count(name, "out_valid pulses", N_OUT, n_out);
    @(negedge clk);
    if (done || busy) begin
        $display("%s: done or busy still high the cycle after done", name);
        error_count++;
    end
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic quiet_after_reset();
    int errs_before;
    int i;
    errs_before = error_count;
    for (i = 0; i < 2 * `CONV_TAPS; i++) begin
        @(negedge clk);
        if (busy || out_valid || done) begin
            $display("quiet_after_reset: busy, out_valid or done high with no start");
            error_count++;
        end
    end
    finish_test("quiet_after_reset", errs_before);
endtask

task automatic identity_kernel();
    int errs_before;
    int a;
    errs_before = error_count;
    for (a = 0; a < IMG_PIX; a++) begin
        img[a] = pixel_t'(a * 5 + 7);   // crosses 127 so some outputs clamp
    end
    for (a = 0; a < `CONV_TAPS; a++) begin
        kern[a] = (a == `CONV_TAPS / 2) ? 8'sd1 : 8'sd0;
    end
    load_image();
    load_kernel();
    set_requant(16'sd0, 16'd1, 5'd0);
    run_and_check("identity");
    finish_test("identity_kernel", errs_before);
endtask

task automatic random_kernels();
    int errs_before;
    int i;
    int a;
    errs_before = error_count;
    for (i = 0; i < 3; i++) begin
        for (a = 0; a < IMG_PIX; a++) begin
            img[a] = pixel_t'($urandom);
        end
        for (a = 0; a < `CONV_TAPS; a++) begin
            kern[a] = weight_t'($urandom);
        end
        load_image();
        load_kernel();
        set_requant(bias_t'(int'($urandom_range(0, 4000)) - 2000),
                    scale_t'($urandom_range(1, 255)), rank_t'($urandom_range(12, 20)));
        run_and_check($sformatf("random_%0d", i));
    end
    finish_test("random_kernels", errs_before);
endtask

task automatic saturation_limits();
    int errs_before;
    int a;
    errs_before = error_count;
    for (a = 0; a < IMG_PIX; a++) begin
        img[a] = pixel_t'(8'hc0 | a);
    end
    for (a = 0; a < `CONV_TAPS; a++) begin
        kern[a] = 8'sd127;
    end
    load_image();
    load_kernel();
    set_requant(16'sd1000, 16'd4, 5'd0);
    run_and_check("saturate_high");
    for (a = 0; a < `CONV_TAPS; a++) begin
        kern[a] = -8'sd128;
    end
    load_kernel();
    set_requant(-16'sd1000, 16'd4, 5'd0);
    run_and_check("saturate_low");
    finish_test("saturation_limits", errs_before);
endtask

task automatic back_to_back_runs();
    int errs_before;
    int a;
    errs_before = error_count;
    for (a = 0; a < IMG_PIX; a++) begin
        img[a] = pixel_t'(a * 3 + 1);
    end
    for (a = 0; a < `CONV_TAPS; a++) begin
        kern[a] = weight_t'(a - 4);
    end
    load_image();
    load_kernel();
    set_requant(16'sd50, 16'd3, 5'd2);
    run_and_check("rerun_first");
    // only the top left tap, so any carried sum shows up at once
    for (a = 0; a < `CONV_TAPS; a++) begin
        kern[a] = (a == 0) ? 8'sd1 : 8'sd0;
    end
    load_kernel();
    run_and_check("rerun_second");
    finish_test("back_to_back_runs", errs_before);
endtask

`endif

/* verification/conv_engine_tb.sv */
`include "conv_settings.svh"

module conv_engine_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import conv_pkg::*;

    localparam int IMG_PIX = `CONV_IMG_W * `CONV_IMG_H;
    localparam int N_OUT   = `CONV_OUT_W * `CONV_OUT_H;
    localparam int N_RUNS  = 8;
    // loads, sweep, drain and a few idle cycles for one run
    localparam int RUN_LEN = IMG_PIX + `CONV_TAPS + N_OUT * `CONV_TAPS + `CONV_DRAIN + 16;
    localparam int MAX_CYCLES = 2 * N_RUNS * RUN_LEN + 100;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic                    pix_wr_en;
    logic [`CONV_ADDR_W-1:0] pix_wr_addr;
    pixel_t                  pix_wr_data;
    logic                    w_wr_en;
    logic [`CONV_TAP_W-1:0]  w_wr_idx;
    weight_t                 w_wr_data;
    bias_t                   bias;
    scale_t                  scale;
    rank_t                   rank;
    logic                    busy;
    logic                    out_valid;
    coord_t                  out_x;
    coord_t                  out_y;
    qout_t                   out_data;
    logic                    done;

    pixel_t  img [IMG_PIX];        // copy of the feature map in the DUT
    weight_t kern [`CONV_TAPS];    // copy of the kernel, raster order
    int      error_count;
    int      tests_run;
    int      tests_failed;
    int      cycle_cnt;

    conv_engine uut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;   // 40 ns period

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic qout_t model_out(input int ox, input int oy);
        longint s;
        int     kx;
        int     ky;
        s = 0;
        for (ky = 0; ky < `CONV_K; ky++) begin
            for (kx = 0; kx < `CONV_K; kx++) begin
                s += longint'(img[(oy + ky) * `CONV_IMG_W + ox + kx])
                     * longint'(kern[ky * `CONV_K + kx]);
            end
        end
        s = s + longint'(bias);
        s = s * longint'(scale);   // scale is unsigned
        s = s >>> rank;
        if (s > 127) begin
            return 8'sd127;
        end else if (s < -128) begin
            return -8'sd128;
        end
        return qout_t'(s);
    endfunction

    `include "conv_engine_tests.svh"

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: simulation did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h702de965));
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        rst_n        = 1'b0;
        start        = 1'b0;
        pix_wr_en    = 1'b0;
        pix_wr_addr  = '0;
        pix_wr_data  = '0;
        w_wr_en      = 1'b0;
        w_wr_idx     = '0;
        w_wr_data    = '0;
        bias         = '0;
        scale        = '0;
        rank         = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        quiet_after_reset();
        identity_kernel();
        random_kernels();
        saturation_limits();
        back_to_back_runs();

        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, uut.u_assertions.fail_count);
        if (error_count == 0 && uut.u_assertions.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
